//--- hbus_cfg_pkg.sv
package hbus_cfg_pkg;

  // **************************************************
  // wishbone side
  // **************************************************
  localparam int WB_DATA_W = 32;
  localparam int WB_ADDR_W = 32;

  // **************************************************
  // hyperbus side
  // **************************************************
  localparam int HBUS_DATA_W = 16;
  localparam int HBUS_MASK_W = HBUS_DATA_W / 8;  // one bit per byte

  localparam int NUM_BANKS    = 4;
  localparam int BANK_SEL_W   = $clog2(NUM_BANKS);
  localparam int WORD_IDX_W   = 5;                // 32 words per bank
  localparam int BEAT_ADR_W   = WORD_IDX_W + 1;   // two halfwords per word

  // busy cycles before a bank answers
  localparam int BANK_LATENCY = 2;

endpackage

//--- hbus_types_pkg.sv
package hbus_types_pkg;

  import hbus_cfg_pkg::*;

  // byte address on the wishbone side, raw or split into fields
  typedef union packed {
    logic [WB_ADDR_W-1:0] flat;
    struct packed {
      // must be zero, anything else is an error
      logic [WB_ADDR_W-BANK_SEL_W-WORD_IDX_W-$clog2(WB_DATA_W/8)-1:0] unmapped;
      logic [BANK_SEL_W-1:0]             bank;
      logic [WORD_IDX_W-1:0]             word;
      logic [$clog2(WB_DATA_W/8)-1:0]    byte_ofs;  // ignored
    } fields;
  } wb_addr_u;

endpackage

//--- hyperbus_wishbone.sv
module hyperbus_wishbone (
  input  logic                                 wb_clk,
  input  logic                                 wb_rst,
  input  logic [hbus_cfg_pkg::WB_ADDR_W-1:0]   wb_adr_i,
  input  logic [hbus_cfg_pkg::WB_DATA_W-1:0]   wb_dat_i,
  input  logic                                 wb_we_i,
  input  logic [hbus_cfg_pkg::WB_DATA_W/8-1:0] wb_sel_i,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  output logic [hbus_cfg_pkg::WB_DATA_W-1:0]   wb_dat_o,
  output logic                                 wb_ack_o,
  output logic                                 wb_err_o,
  output logic                                 rrq_o,
  output logic                                 wrq_o,
  output logic [hbus_cfg_pkg::WB_ADDR_W-1:0]   adr_o,
  output logic [hbus_cfg_pkg::WB_DATA_W-1:0]   tx_dat_o,
  output logic [hbus_cfg_pkg::WB_DATA_W/8-1:0] tx_mask_o,
  input  logic                                 tx_done_i,
  input  logic                                 rx_valid_i,
  input  logic [hbus_cfg_pkg::WB_DATA_W-1:0]   rx_dat_i
);
  import hbus_types_pkg::*;

  localparam logic [3:0] ST_IDLE  = 4'b0001;
  localparam logic [3:0] ST_WRITE = 4'b0010;
  localparam logic [3:0] ST_READ  = 4'b0100;
  localparam logic [3:0] ST_ERR   = 4'b1000;

  logic [3:0] state;
  wb_addr_u   req_adr;
  logic       req_new;

  assign req_adr = wb_adr_i;
  // master still holds stb in the cycle after ack or err
  assign req_new = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state    <= ST_IDLE;
      rrq_o    <= 1'b0;
      wrq_o    <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      rrq_o    <= 1'b0;  // all pulses
      wrq_o    <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req_new) begin
            if (req_adr.fields.unmapped != '0) begin
              wb_err_o <= 1'b1;
              state    <= ST_ERR;
            end else if (wb_we_i) begin
              wrq_o <= 1'b1;
              state <= ST_WRITE;
            end else begin
              rrq_o <= 1'b1;
              state <= ST_READ;
            end
          end
        end
        ST_WRITE: begin
          if (tx_done_i) begin
            wb_ack_o <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        ST_READ: begin
          if (rx_valid_i) begin
            wb_ack_o <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        ST_ERR:  state <= ST_IDLE;  // err is out this cycle
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk) begin
    if (state == ST_IDLE && req_new) begin
      adr_o     <= wb_adr_i;
      tx_dat_o  <= wb_dat_i;
      tx_mask_o <= ~wb_sel_i;  // 1 = keep byte
    end
    if (state == ST_READ && rx_valid_i) begin
      wb_dat_o <= rx_dat_i;
    end
  end

endmodule

//--- hbus_sequencer.sv
module hbus_sequencer (
  input  logic                                 wb_clk,
  input  logic                                 wb_rst,
  input  logic                                 rrq_i,
  input  logic                                 wrq_i,
  input  logic [hbus_cfg_pkg::WB_ADDR_W-1:0]   adr_i,
  input  logic [hbus_cfg_pkg::WB_DATA_W-1:0]   tx_dat_i,
  input  logic [hbus_cfg_pkg::WB_DATA_W/8-1:0] tx_mask_i,
  output logic [hbus_cfg_pkg::NUM_BANKS-1:0]   beat_req_o,
  output logic                                 beat_we_o,
  output logic [hbus_cfg_pkg::BEAT_ADR_W-1:0]  beat_adr_o,
  output logic [hbus_cfg_pkg::HBUS_DATA_W-1:0] beat_dat_o,
  output logic [hbus_cfg_pkg::HBUS_MASK_W-1:0] beat_mask_o,
  input  logic [hbus_cfg_pkg::NUM_BANKS-1:0]   bank_ready_i,
  input  logic [hbus_cfg_pkg::NUM_BANKS-1:0]   bank_valid_i,
  output logic                                 tx_done_o
);
  import hbus_cfg_pkg::*;
  import hbus_types_pkg::*;

  wb_addr_u               in_adr;
  wb_addr_u               adr_q;
  logic                   we_q;
  logic [WB_DATA_W-1:0]   dat_q;
  logic [WB_DATA_W/8-1:0] mask_q;
  logic                   busy;
  logic                   beat;       // 0 = low half, 1 = high half
  logic                   beat_done;

  assign in_adr    = adr_i;
  assign beat_done = busy & (bank_ready_i[adr_q.fields.bank] | bank_valid_i[adr_q.fields.bank]);

  // **************************************************
  // beat issue
  // **************************************************
  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      busy       <= 1'b0;
      beat       <= 1'b0;
      beat_req_o <= '0;
    end else begin
      beat_req_o <= '0;
      if (rrq_i | wrq_i) begin
        busy       <= 1'b1;
        beat       <= 1'b0;
        beat_req_o <= NUM_BANKS'(1) << in_adr.fields.bank;
      end else if (beat_done) begin
        if (!beat) begin
          beat       <= 1'b1;
          beat_req_o <= NUM_BANKS'(1) << adr_q.fields.bank;  // same bank, upper half
        end else begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge wb_clk) begin
    if (rrq_i | wrq_i) begin
      adr_q  <= adr_i;
      we_q   <= wrq_i;
      dat_q  <= tx_dat_i;
      mask_q <= tx_mask_i;
    end
  end

  assign beat_we_o   = we_q;
  assign beat_adr_o  = {adr_q.fields.word, beat};
  assign beat_dat_o  = beat ? dat_q[WB_DATA_W-1 -: HBUS_DATA_W] : dat_q[HBUS_DATA_W-1:0];
  assign beat_mask_o = beat ? mask_q[2*HBUS_MASK_W-1 -: HBUS_MASK_W]
                            : mask_q[HBUS_MASK_W-1:0];

  // second ready of a write
  assign tx_done_o = beat_done & beat & we_q;

endmodule

//--- hbus_ram_bank.sv
module hbus_ram_bank (
  input  logic                                 wb_clk,
  input  logic                                 wb_rst,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [hbus_cfg_pkg::BEAT_ADR_W-1:0]  adr_i,
  input  logic [hbus_cfg_pkg::HBUS_DATA_W-1:0] dat_i,
  input  logic [hbus_cfg_pkg::HBUS_MASK_W-1:0] mask_i,
  output logic                                 ready_o,
  output logic                                 valid_o,
  output logic [hbus_cfg_pkg::HBUS_DATA_W-1:0] dat_o
);
  import hbus_cfg_pkg::*;

  logic [HBUS_DATA_W-1:0] mem [2**BEAT_ADR_W];

  logic                             busy;
  logic [$clog2(BANK_LATENCY+1)-1:0] cnt;
  logic                             we_q;
  logic [BEAT_ADR_W-1:0]            adr_q;
  logic [HBUS_DATA_W-1:0]           dat_q;
  logic [HBUS_MASK_W-1:0]           mask_q;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      busy    <= 1'b0;
      cnt     <= '0;
      ready_o <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      ready_o <= 1'b0;
      valid_o <= 1'b0;
      if (req_i) begin
        busy <= 1'b1;
        cnt  <= $bits(cnt)'(BANK_LATENCY - 1);
      end else if (busy) begin
        if (cnt == '0) begin
          busy    <= 1'b0;
          ready_o <= we_q;
          valid_o <= ~we_q;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  // array access on the last busy cycle
  always_ff @(posedge wb_clk) begin
    if (req_i) begin
      we_q   <= we_i;
      adr_q  <= adr_i;
      dat_q  <= dat_i;
      mask_q <= mask_i;
    end
    if (busy && cnt == '0) begin
      if (we_q) begin
        for (int b = 0; b < HBUS_MASK_W; b++) begin
          if (!mask_q[b]) mem[adr_q][b*8 +: 8] <= dat_q[b*8 +: 8];
        end
      end else begin
        dat_o <= mem[adr_q];
      end
    end
  end

endmodule

//--- hbus_read_gather.sv
module hbus_read_gather (
  input  logic                                                wb_clk,
  input  logic                                                wb_rst,
  input  logic [hbus_cfg_pkg::NUM_BANKS-1:0]                  bank_valid_i,
  input  logic [hbus_cfg_pkg::NUM_BANKS*hbus_cfg_pkg::HBUS_DATA_W-1:0] bank_dat_i,
  output logic                                                rx_valid_o,
  output logic [hbus_cfg_pkg::WB_DATA_W-1:0]                  rx_dat_o
);
  import hbus_cfg_pkg::*;

  logic                   any_valid;
  logic [HBUS_DATA_W-1:0] sel_dat;
  logic [HBUS_DATA_W-1:0] low_q;    // beat 0
  logic                   second;   // next valid is beat 1

  assign any_valid = |bank_valid_i;

  // only one bank answers at a time
  always_comb begin
    sel_dat = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_valid_i[i]) sel_dat = sel_dat | bank_dat_i[i*HBUS_DATA_W +: HBUS_DATA_W];
    end
  end

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      second <= 1'b0;
    end else if (any_valid) begin
      second <= ~second;
    end
  end

  always_ff @(posedge wb_clk) begin
    if (any_valid && !second) begin
      low_q <= sel_dat;
    end
  end

  // **************************************************
  // word out on the high beat
  // **************************************************
  assign rx_valid_o = any_valid & second;
  assign rx_dat_o   = {sel_dat, low_q};

endmodule

//--- hbus_subsys.sv
module hbus_subsys (
  input  logic                                 wb_clk,
  input  logic                                 wb_rst,
  input  logic [hbus_cfg_pkg::WB_ADDR_W-1:0]   wb_adr_i,
  input  logic [hbus_cfg_pkg::WB_DATA_W-1:0]   wb_dat_i,
  input  logic                                 wb_we_i,
  input  logic [hbus_cfg_pkg::WB_DATA_W/8-1:0] wb_sel_i,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  output logic [hbus_cfg_pkg::WB_DATA_W-1:0]   wb_dat_o,
  output logic                                 wb_ack_o,
  output logic                                 wb_err_o
);
  import hbus_cfg_pkg::*;

  logic                          rrq;
  logic                          wrq;
  logic [WB_ADDR_W-1:0]          adr;
  logic [WB_DATA_W-1:0]          tx_dat;
  logic [WB_DATA_W/8-1:0]        tx_mask;
  logic                          tx_done;
  logic                          rx_valid;
  logic [WB_DATA_W-1:0]          rx_dat;
  logic [NUM_BANKS-1:0]          beat_req;
  logic                          beat_we;
  logic [BEAT_ADR_W-1:0]         beat_adr;
  logic [HBUS_DATA_W-1:0]        beat_dat;
  logic [HBUS_MASK_W-1:0]        beat_mask;
  logic [NUM_BANKS-1:0]          bank_ready;
  logic [NUM_BANKS-1:0]          bank_valid;
  logic [NUM_BANKS*HBUS_DATA_W-1:0] bank_dat;

  hyperbus_wishbone u_fe (
    .wb_clk, .wb_rst,
    .wb_adr_i, .wb_dat_i, .wb_we_i, .wb_sel_i, .wb_cyc_i, .wb_stb_i,
    .wb_dat_o, .wb_ack_o, .wb_err_o,
    .rrq_o(rrq), .wrq_o(wrq), .adr_o(adr), .tx_dat_o(tx_dat), .tx_mask_o(tx_mask),
    .tx_done_i(tx_done), .rx_valid_i(rx_valid), .rx_dat_i(rx_dat)
  );

  hbus_sequencer u_seq (
    .wb_clk, .wb_rst,
    .rrq_i(rrq), .wrq_i(wrq), .adr_i(adr), .tx_dat_i(tx_dat), .tx_mask_i(tx_mask),
    .beat_req_o(beat_req), .beat_we_o(beat_we), .beat_adr_o(beat_adr),
    .beat_dat_o(beat_dat), .beat_mask_o(beat_mask),
    .bank_ready_i(bank_ready), .bank_valid_i(bank_valid),
    .tx_done_o(tx_done)
  );

  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    hbus_ram_bank u_bank (
      .wb_clk, .wb_rst,
      .req_i(beat_req[g]), .we_i(beat_we), .adr_i(beat_adr),
      .dat_i(beat_dat), .mask_i(beat_mask),
      .ready_o(bank_ready[g]), .valid_o(bank_valid[g]),
      .dat_o(bank_dat[g*HBUS_DATA_W +: HBUS_DATA_W])
    );
  end

  hbus_read_gather u_gather (
    .wb_clk, .wb_rst,
    .bank_valid_i(bank_valid), .bank_dat_i(bank_dat),
    .rx_valid_o(rx_valid), .rx_dat_o(rx_dat)
  );

endmodule

//--- tb_hbus_subsys_assert.sv
module tb_hbus_subsys_assert (
  input logic wb_clk,
  input logic wb_rst,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic err_i
);

  int fail_cnt = 0;  // read by the testbench top

  ack_err_excl: assert property (@(posedge wb_clk) disable iff (wb_rst)
    !(ack_i && err_i)) else begin
    $error("ack and err high in the same cycle");
    fail_cnt++;
  end

  // one response per request
  no_back_to_back: assert property (@(posedge wb_clk) disable iff (wb_rst)
    (ack_i || err_i) |=> !(ack_i || err_i)) else begin
    $error("ack or err in two cycles in a row");
    fail_cnt++;
  end

  only_on_request: assert property (@(posedge wb_clk) disable iff (wb_rst)
    (ack_i || err_i) |-> (cyc_i && stb_i)) else begin
    $error("ack or err without a request");
    fail_cnt++;
  end

  quiet_after_reset: assert property (@(posedge wb_clk)
    wb_rst |=> !(ack_i || err_i)) else begin
    $error("ack or err right after reset");
    fail_cnt++;
  end

endmodule

bind hyperbus_wishbone tb_hbus_subsys_assert u_assert (
  .wb_clk(wb_clk), .wb_rst(wb_rst),
  .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .ack_i(wb_ack_o), .err_i(wb_err_o)
);

//--- tb_hbus_subsys.sv
module tb_hbus_subsys;
  import hbus_cfg_pkg::*;
  import hbus_types_pkg::*;

  localparam int NUM_OPS  = 128 + 8 + 8 + 4 + 200;  // fill, banks, sel, err, random
  localparam int MAX_WAIT = 12;
  localparam int LIMIT    = NUM_OPS * MAX_WAIT + 100;

  logic                   wb_clk, wb_rst, wb_we_i, wb_cyc_i, wb_stb_i;
  logic [WB_ADDR_W-1:0]   wb_adr_i;
  logic [WB_DATA_W-1:0]   wb_dat_i, wb_dat_o;
  logic [WB_DATA_W/8-1:0] wb_sel_i;
  logic                   wb_ack_o, wb_err_o;

  logic [WB_DATA_W-1:0] ref_mem [NUM_BANKS * 2**WORD_IDX_W];
  logic [WB_DATA_W-1:0] exp_q[$], got_q[$];
  logic [31:0]          lfsr = 32'hff8c_ec95;
  int                   errors = 0, checks = 0, cycles = 0;

  hbus_subsys u_dut (.*);

  initial begin
    wb_clk = 1'b0;
    forever #50 wb_clk = ~wb_clk;
  end

  // **************************************************
  // helpers
  // **************************************************
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int word_index(input logic [31:0] adr);
    wb_addr_u a;
    a.flat = adr;
    return {a.fields.bank, a.fields.word};
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] adr);
    return ref_mem[word_index(adr)];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  // wishbone master, called and returning 10 units after a rising edge
  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic exp_err,
                           output logic [31:0] rdat, output logic acked);
    int   n;
    logic erred;
    n        = 0;
    acked    = 1'b0;
    erred    = 1'b0;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    while (!acked && !erred && n < MAX_WAIT) begin
      @(posedge wb_clk);
      #10;
      n++;
      acked = wb_ack_o;
      erred = wb_err_o;
    end
    rdat = wb_dat_o;
    if (!acked && !erred) begin
      errors++;
      $display("no ack or err within %0d cycles for address %h", MAX_WAIT, adr);
    end else begin
      check("wb_ack_o", acked, !exp_err);
      check("wb_err_o", erred, exp_err);
      @(posedge wb_clk);  // stb still up on the edge that takes the response
      #10;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  task automatic do_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] rdat;
    logic        acked;
    wb_access(1'b1, adr, dat, sel, 1'b0, rdat, acked);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) ref_mem[word_index(adr)][b*8 +: 8] = dat[b*8 +: 8];
    end
  endtask

  task automatic do_read(input logic [31:0] adr);
    logic [31:0] rdat;
    logic        acked;
    wb_access(1'b0, adr, '0, 4'hf, 1'b0, rdat, acked);
    if (acked) begin
      exp_q.push_back(ref_read(adr));
      got_q.push_back(rdat);
    end
  endtask

  // read data compare
  always @(posedge wb_clk) begin
    while (exp_q.size() > 0) check("wb_dat_o", got_q.pop_front(), exp_q.pop_front());
  end

  initial begin
    while (cycles < LIMIT) begin
      @(posedge wb_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d checks, %0d errors", cycles, checks, errors);
    $display("Some tests failed");
    $finish;
  end

  // **************************************************
  // test sequence
  // **************************************************
  initial begin
    logic [31:0] adr, rdat;
    logic        acked;
    logic [3:0]  part_sel [4];
    part_sel = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    wb_rst = 1'b1;
    {wb_we_i, wb_cyc_i, wb_stb_i, wb_adr_i, wb_dat_i, wb_sel_i} = '0;
    repeat (2) @(posedge wb_clk);
    #10 wb_rst = 1'b0;
    repeat (4) begin  // quiet bus after reset
      @(posedge wb_clk);
      #10;
      check("wb_ack_o", wb_ack_o, 1'b0);
      check("wb_err_o", wb_err_o, 1'b0);
    end
    for (int i = 0; i < NUM_BANKS * 2**WORD_IDX_W; i++) do_write(i << 2, take_bits(32), 4'hf);
    for (int b = 0; b < NUM_BANKS; b++) begin
      adr = {b[1:0], 5'(take_bits(5)), 2'b00};
      do_write(adr, take_bits(32), 4'hf);
      do_read(adr);
    end
    foreach (part_sel[i]) begin
      adr = take_bits(9);
      do_write(adr, take_bits(32), part_sel[i]);
      do_read(adr);
    end
    repeat (2) begin  // unmapped bit set, aliased word must stay
      adr = take_bits(9);
      wb_access(1'b1, adr | (32'h1 << (9 + take_bits(5) % 23)), 32'hdead_beef, 4'hf,
                1'b1, rdat, acked);
      do_read(adr);
    end
    repeat (200) begin
      adr = take_bits(9);
      if (take_bits(1)) do_write(adr, take_bits(32), take_bits(4));
      else do_read(adr);
    end
    repeat (2) @(posedge wb_clk);
    errors += u_dut.u_fe.u_assert.fail_cnt;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- hbus_subsys.f
hbus_cfg_pkg.sv
hbus_types_pkg.sv
hyperbus_wishbone.sv
hbus_sequencer.sv
hbus_ram_bank.sv
hbus_read_gather.sv
hbus_subsys.sv
tb_hbus_subsys_assert.sv
tb_hbus_subsys.sv

//--- Bender.yml
package:
  name: hbus_subsys

sources:
  - hbus_cfg_pkg.sv
  - hbus_types_pkg.sv
  - hyperbus_wishbone.sv
  - hbus_sequencer.sv
  - hbus_ram_bank.sv
  - hbus_read_gather.sv
  - hbus_subsys.sv
  - target: test
    files:
      - tb_hbus_subsys_assert.sv
      - tb_hbus_subsys.sv
